// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       := tb_fabric
FILELIST  := project.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Regression failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); test $$status -eq 0
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dv/fabric_sva.sv
`timescale 1ns/1ps

module fabric_sva (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  req_valid,
    input logic                  req_ready,
    input fabric_pkg::host_req_t req,
    input logic                  rsp_valid,
    input logic                  rsp_ready,
    input fabric_pkg::host_rsp_t rsp
);

    logic       acc_q;
    logic [7:0] credit;
    int         err_count = 0;

    // requests accepted two or more edges back, not yet answered.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_q  <= 1'b0;
            credit <= '0;
        end else begin
            acc_q  <= req_valid & req_ready;
            credit <= credit + {7'd0, acc_q} - {7'd0, rsp_valid & rsp_ready};
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable(req))
        else begin
            err_count++;
            $error("request changed while stalled");
        end

    a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else begin
            err_count++;
            $error("response changed while stalled");
        end

    a_rsp_reset: assert property (@(posedge clk) !rst_n |=> !rsp_valid)
        else begin
            err_count++;
            $error("response valid right after reset");
        end

    a_rsp_orphan: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && rsp_ready |-> credit != 8'd0)
        else begin
            err_count++;
            $error("response without an earlier accepted request");
        end

endmodule

bind fabric_top fabric_sva u_sva (
    .clk       (clk),
    .rst_n     (rst_n),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .req       (req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
);

// File: dv/tb_fabric.sv
`timescale 1ns/1ps

module tb_fabric;

    import fabric_pkg::*;

    localparam int          n_rom     = 8;
    localparam int          n_ram     = 16;
    localparam int          n_mix     = 60;
    localparam logic [31:0] seed_init = 32'h7ced_e602;

    // all transactions of all tests.
    localparam int planned_txn = 1 + (n_rom + 4) + (2 * n_ram + 2) + 7 + 7 + n_mix;

    logic       clk;
    logic       rst_n;
    logic       req_valid;
    logic       req_ready;
    host_req_t  req;
    logic       rsp_valid;
    logic       rsp_ready;
    host_rsp_t  rsp;
    logic [6:0] hex0;
    logic [6:0] hex1;
    logic [6:0] hex2;
    logic [6:0] hex3;
    logic [6:0] hex4;
    logic [6:0] hex5;

    integer      seed;
    integer      ready_seed;
    int          pass_count;
    int          fail_count;
    int          test_fails;
    int          sent_count;
    int          recv_count;
    logic        rand_ready;
    host_rsp_t   exp_q [$];
    logic [15:0] ram_written [$];
    logic [7:0]  ram_shadow [0:16383];
    logic [7:0]  hex_shadow [0:2];

    fabric_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp),
        .hex0      (hex0),
        .hex1      (hex1),
        .hex2      (hex2),
        .hex3      (hex3),
        .hex4      (hex4),
        .hex5      (hex5)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ******************************
    // reference model
    // ******************************

    // lit segments as gfedcba, then inverted.
    function automatic logic [6:0] seg_ref(input logic [3:0] nib);
        logic [6:0] lit;
        case (nib)
            4'h0:    lit = 7'h3F;
            4'h1:    lit = 7'h06;
            4'h2:    lit = 7'h5B;
            4'h3:    lit = 7'h4F;
            4'h4:    lit = 7'h66;
            4'h5:    lit = 7'h6D;
            4'h6:    lit = 7'h7D;
            4'h7:    lit = 7'h07;
            4'h8:    lit = 7'h7F;
            4'h9:    lit = 7'h6F;
            4'hA:    lit = 7'h77;
            4'hB:    lit = 7'h7C;
            4'hC:    lit = 7'h39;
            4'hD:    lit = 7'h5E;
            4'hE:    lit = 7'h79;
            default: lit = 7'h71;
        endcase
        return ~lit;
    endfunction

    function automatic host_rsp_t ref_read(input logic [15:0] addr, input logic we);
        host_rsp_t r;
        r.wr_ack = we;
        r.rdata  = 8'h00;
        if (!we) begin
            if (addr >= rom_base) begin
                r.rdata = addr[7:0] ^ addr[15:8];
            end else if (addr[15:2] == hex_base[15:2]) begin
                r.rdata = (addr[1:0] == 2'd3) ? 8'h00 : hex_shadow[addr[1:0]];
            end else if (addr <= ram_limit) begin
                r.rdata = ram_shadow[addr[13:0]];
            end else begin
                r.rdata = unmapped_data;
            end
        end
        return r;
    endfunction

    task automatic record_write(input logic [15:0] addr, input logic [7:0] data);
        if (addr[15:2] == hex_base[15:2]) begin
            if (addr[1:0] != 2'd3) begin
                hex_shadow[addr[1:0]] = data;
            end
        end else if (addr <= ram_limit) begin
            ram_shadow[addr[13:0]] = data;
        end
    endtask

    // ******************************
    // driver and checks
    // ******************************

    task automatic note_fail();
        fail_count++;
        test_fails++;
    endtask

    task automatic send(input logic [15:0] addr, input logic [7:0] data, input logic we);
        req_valid = 1'b1;
        req.addr  = addr;
        req.wdata = data;
        req.we    = we;
        do begin
            @(posedge clk);
        end while (!req_ready);
        exp_q.push_back(ref_read(addr, we));
        if (we) begin
            record_write(addr, data);
        end
        sent_count++;
        #1;
        req_valid = 1'b0;
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        #1;
    endtask

    task automatic compare_rsp(input host_rsp_t want, input host_rsp_t got);
        if (got.rdata != want.rdata) begin
            $display("[FAIL] t=%0t rsp.rdata expected %h got %h", $time, want.rdata, got.rdata);
            note_fail();
        end else begin
            pass_count++;
        end
        if (got.wr_ack != want.wr_ack) begin
            $display("[FAIL] t=%0t rsp.wr_ack expected %b got %b",
                     $time, want.wr_ack, got.wr_ack);
            note_fail();
        end else begin
            pass_count++;
        end
    endtask

    task automatic check_hex();
        logic [6:0] got [0:5];
        logic [6:0] want;
        got[0] = hex0;
        got[1] = hex1;
        got[2] = hex2;
        got[3] = hex3;
        got[4] = hex4;
        got[5] = hex5;
        for (int d = 0; d < 6; d++) begin
            want = seg_ref(d[0] ? hex_shadow[d / 2][7:4] : hex_shadow[d / 2][3:0]);
            if (got[d] != want) begin
                $display("[FAIL] t=%0t hex%0d expected %b got %b", $time, d, want, got[d]);
                note_fail();
            end else begin
                pass_count++;
            end
        end
    endtask

    task automatic finish_test(input string name);
        if (test_fails == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_fails);
        end
        test_fails = 0;
    endtask

    // compares every transferred response with the queue head.
    initial begin
        forever begin
            @(posedge clk);
            if (rst_n && rsp_valid && rsp_ready) begin
                recv_count++;
                if (exp_q.size() == 0) begin
                    $display("t=%0t a response arrived with no request outstanding", $time);
                    note_fail();
                end else begin
                    compare_rsp(exp_q.pop_front(), rsp);
                end
            end
        end
    end

    // random back-pressure only while enabled.
    initial begin
        forever begin
            @(posedge clk);
            #1;
            if (rand_ready) begin
                rsp_ready = 1'($random(ready_seed));
            end else begin
                rsp_ready = 1'b1;
            end
        end
    end

    initial begin
        repeat (planned_txn * 40 + 200) @(posedge clk);
        $display("watchdog expired before the tests completed");
        $display("Regression failed");
        $finish;
    end

    // ******************************
    // tests
    // ******************************

    initial begin
        logic [31:0] rnd;
        logic [15:0] addr;
        logic [15:0] tmp;
        logic [15:0] order [$];
        int          j;
        int          kind;

        seed       = seed_init;
        ready_seed = ~seed_init;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req        = '0;
        rsp_ready  = 1'b1;
        rand_ready = 1'b0;
        pass_count = 0;
        fail_count = 0;
        test_fails = 0;
        sent_count = 0;
        recv_count = 0;
        for (int k = 0; k < 3; k++) begin
            hex_shadow[k] = 8'h00;
        end
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_hex();
        send(hex_base, 8'h00, 1'b0);
        drain();
        finish_test("reset_state");

        for (int i = 0; i < n_rom; i++) begin
            rnd = $random(seed);
            send({1'b1, rnd[14:0]}, 8'h00, 1'b0);
        end
        for (int i = 0; i < 2; i++) begin
            rnd  = $random(seed);
            addr = {1'b1, rnd[14:0]};
            send(addr, rnd[23:16], 1'b1);
            send(addr, 8'h00, 1'b0);
        end
        drain();
        finish_test("rom_rule");

        for (int i = 0; i < n_ram; i++) begin
            rnd = $random(seed);
            send({2'b00, rnd[13:0]}, rnd[23:16], 1'b1);
            ram_written.push_back({2'b00, rnd[13:0]});
        end
        // overwrite one address, the read must see the last value.
        rnd = $random(seed);
        send(ram_written[0], rnd[7:0], 1'b1);
        ram_written.push_back(ram_written[0]);
        order = ram_written;
        for (int i = order.size() - 1; i > 0; i--) begin
            j        = $unsigned($random(seed)) % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        foreach (order[i]) begin
            send(order[i], 8'h00, 1'b0);
        end
        drain();
        finish_test("ram_rw");

        for (int k = 0; k < 3; k++) begin
            rnd = $random(seed);
            send(hex_base + 16'(k), rnd[7:0], 1'b1);
        end
        drain();
        check_hex();
        for (int k = 0; k < 4; k++) begin
            send(hex_base + 16'(k), 8'h00, 1'b0);
        end
        drain();
        finish_test("hex_display");

        send(16'h4000, 8'h00, 1'b0);
        send(16'h5000, 8'h00, 1'b0);
        send(16'h7FEF, 8'h00, 1'b0);
        send(16'h7FF4, 8'h00, 1'b0);
        send(16'h7FF8, 8'h00, 1'b0);
        send(16'h6000, 8'h5A, 1'b1);
        send(16'h6000, 8'h00, 1'b0);
        drain();
        finish_test("unmapped");

        rand_ready = 1'b1;
        for (int i = 0; i < n_mix; i++) begin
            rnd  = $random(seed);
            kind = $unsigned($random(seed)) % 7;
            case (kind)
                0: begin
                    send({2'b00, rnd[13:0]}, rnd[23:16], 1'b1);
                    ram_written.push_back({2'b00, rnd[13:0]});
                end
                1: send(ram_written[rnd[31:16] % ram_written.size()], 8'h00, 1'b0);
                2: send({1'b1, rnd[14:0]}, 8'h00, 1'b0);
                3: send({1'b1, rnd[14:0]}, rnd[23:16], 1'b1);
                4: send(hex_base + 16'(rnd[31:16] % 3), rnd[7:0], 1'b1);
                5: send(hex_base + {14'd0, rnd[1:0]}, 8'h00, 1'b0);
                default: send({4'h4, rnd[11:0]}, 8'h00, 1'b0);
            endcase
        end
        drain();
        rand_ready = 1'b0;
        check_hex();
        if (recv_count != sent_count) begin
            $display("%0d responses received for %0d requests", recv_count, sent_count);
            note_fail();
        end
        finish_test("mixed_stream");

        if (dut.u_sva.err_count != 0) begin
            $display("%0d handshake assertions failed", dut.u_sva.err_count);
            fail_count += dut.u_sva.err_count;
        end

        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: project.f
src/fabric_pkg.sv
src/bus_capture.sv
src/addr_decode.sv
src/main_ram.sv
src/boot_rom.sv
src/hex_display.sv
src/resp_stage.sv
src/fabric_top.sv
dv/fabric_sva.sv
dv/tb_fabric.sv

// File: src/addr_decode.sv
`timescale 1ns/1ps

module addr_decode #(
    parameter int RAM_AW = 14,
    parameter int ROM_AW = 15
) (
    input  logic                  cap_valid,
    input  fabric_pkg::host_req_t cap_req,
    output fabric_pkg::target_e   sel,
    output logic [ROM_AW-1:0]     offset,
    output logic                  ram_we,
    output logic                  hex_we
);

    import fabric_pkg::*;

    localparam logic [16:0] ram_span = 17'd1 << RAM_AW;

    logic [15:0] rel;
    logic [15:0] ram_rel;

    assign ram_rel = cap_req.addr - ram_base;

    always_comb begin
        sel = tgt_none;
        rel = '0;
        if (cap_req.addr >= rom_base) begin
            sel = tgt_rom;
            rel = cap_req.addr - rom_base;
        end else if (cap_req.addr[15:2] == hex_base[15:2]) begin
            sel = tgt_hex;
            rel = {14'd0, cap_req.addr[1:0]};
        end else if (cap_req.addr <= ram_limit && {1'b0, ram_rel} < ram_span) begin
            // ram size follows RAM_AW, the rest is a hole.
            sel = tgt_ram;
            rel = ram_rel;
        end
    end

    assign offset = rel[ROM_AW-1:0];

    // rom and unmapped writes are dropped here.
    assign ram_we = cap_valid & cap_req.we & (sel == tgt_ram);
    assign hex_we = cap_valid & cap_req.we & (sel == tgt_hex);

endmodule

// File: src/boot_rom.sv
`timescale 1ns/1ps

module boot_rom #(
    parameter int ROM_AW = 15
) (
    input  logic              clk,
    input  logic              en,
    input  logic [ROM_AW-1:0] addr,
    output logic [7:0]        rdata
);

    import fabric_pkg::*;

    logic [7:0] mem [0:(2**ROM_AW)-1];

    // each byte is low address byte xor high address byte.
    initial begin
        logic [15:0] full_addr;
        for (int i = 0; i < 2**ROM_AW; i++) begin
            full_addr = rom_base + 16'(i);
            mem[i]    = full_addr[7:0] ^ full_addr[15:8];
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[addr];
        end
    end

endmodule

// File: src/bus_capture.sv
`timescale 1ns/1ps

module bus_capture (
    input  logic                  clk,
    input  logic                  rst_n,

    // host request channel.
    input  logic                  req_valid,
    output logic                  req_ready,
    input  fabric_pkg::host_req_t req,

    // pipeline enable from the response side.
    input  logic                  adv,

    output logic                  cap_valid,
    output fabric_pkg::host_req_t cap_req
);

    logic take;

    // accept only when the whole pipeline moves.
    assign req_ready = adv;
    assign take      = adv & req_valid;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cap_valid <= 1'b0;
        end else if (adv) begin
            // empty slot when nothing transfers.
            cap_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            cap_req <= req;
        end
    end

endmodule

// File: src/fabric_pkg.sv
package fabric_pkg;

    // ******************************
    // address map
    // ******************************

    localparam logic [15:0] ram_base  = 16'h0000;
    localparam logic [15:0] ram_limit = 16'h3FFF;

    // four byte registers, last one reserved.
    localparam logic [15:0] hex_base  = 16'h7FF0;

    // rom runs to the top of the space.
    localparam logic [15:0] rom_base  = 16'h8000;

    // read value for holes in the map.
    localparam logic [7:0]  unmapped_data = 8'hFF;

    // ******************************
    // bus types
    // ******************************

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        we;
    } host_req_t;

    typedef struct packed {
        logic [7:0]  rdata;
        logic        wr_ack;
    } host_rsp_t;

    typedef enum logic [1:0] {
        tgt_ram,
        tgt_rom,
        tgt_hex,
        tgt_none
    } target_e;

endpackage

// File: src/fabric_top.sv
`timescale 1ns/1ps

module fabric_top #(
    parameter int RAM_AW = 14,
    parameter int ROM_AW = 15
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    output logic                  req_ready,
    input  fabric_pkg::host_req_t req,
    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output fabric_pkg::host_rsp_t rsp,
    output logic [6:0]            hex0,
    output logic [6:0]            hex1,
    output logic [6:0]            hex2,
    output logic [6:0]            hex3,
    output logic [6:0]            hex4,
    output logic [6:0]            hex5
);

    import fabric_pkg::*;

    logic              adv;
    logic              cap_valid;
    host_req_t         cap_req;
    target_e           sel;
    logic [ROM_AW-1:0] offset;
    logic              ram_we;
    logic              hex_we;
    logic [7:0]        ram_rdata;
    logic [7:0]        rom_rdata;
    logic [7:0]        hex_rdata;

    // ******************************
    // stage 1, capture and decode
    // ******************************

    bus_capture u_capture (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req       (req),
        .adv       (adv),
        .cap_valid (cap_valid),
        .cap_req   (cap_req)
    );

    addr_decode #(
        .RAM_AW (RAM_AW),
        .ROM_AW (ROM_AW)
    ) u_decode (
        .cap_valid (cap_valid),
        .cap_req   (cap_req),
        .sel       (sel),
        .offset    (offset),
        .ram_we    (ram_we),
        .hex_we    (hex_we)
    );

    // ******************************
    // targets
    // ******************************

    main_ram #(
        .RAM_AW (RAM_AW)
    ) u_ram (
        .clk   (clk),
        .en    (adv),
        .we    (ram_we),
        .addr  (offset[RAM_AW-1:0]),
        .wdata (cap_req.wdata),
        .rdata (ram_rdata)
    );

    boot_rom #(
        .ROM_AW (ROM_AW)
    ) u_rom (
        .clk   (clk),
        .en    (adv),
        .addr  (offset),
        .rdata (rom_rdata)
    );

    hex_display u_hex (
        .clk   (clk),
        .rst_n (rst_n),
        .en    (adv),
        .we    (hex_we),
        .idx   (offset[1:0]),
        .wdata (cap_req.wdata),
        .rdata (hex_rdata),
        .hex0  (hex0),
        .hex1  (hex1),
        .hex2  (hex2),
        .hex3  (hex3),
        .hex4  (hex4),
        .hex5  (hex5)
    );

    resp_stage u_resp (
        .clk       (clk),
        .rst_n     (rst_n),
        .cap_valid (cap_valid),
        .is_write  (cap_req.we),
        .sel       (sel),
        .ram_rdata (ram_rdata),
        .rom_rdata (rom_rdata),
        .hex_rdata (hex_rdata),
        .adv       (adv),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp       (rsp)
    );

endmodule

// File: src/hex_display.sv
`timescale 1ns/1ps

module hex_display (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       en,
    input  logic       we,
    input  logic [1:0] idx,
    input  logic [7:0] wdata,
    output logic [7:0] rdata,
    output logic [6:0] hex0,
    output logic [6:0] hex1,
    output logic [6:0] hex2,
    output logic [6:0] hex3,
    output logic [6:0] hex4,
    output logic [6:0] hex5
);

    logic [7:0] disp_q [0:2];

    // active low, bit 0 is segment a.
    function automatic logic [6:0] seg7(input logic [3:0] nib);
        logic [6:0] seg;
        case (nib)
            4'h0:    seg = 7'b1000000;
            4'h1:    seg = 7'b1111001;
            4'h2:    seg = 7'b0100100;
            4'h3:    seg = 7'b0110000;
            4'h4:    seg = 7'b0011001;
            4'h5:    seg = 7'b0010010;
            4'h6:    seg = 7'b0000010;
            4'h7:    seg = 7'b1111000;
            4'h8:    seg = 7'b0000000;
            4'h9:    seg = 7'b0010000;
            4'hA:    seg = 7'b0001000;
            4'hB:    seg = 7'b0000011;
            4'hC:    seg = 7'b1000110;
            4'hD:    seg = 7'b0100001;
            4'hE:    seg = 7'b0000110;
            default: seg = 7'b0001110;
        endcase
        return seg;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            disp_q[0] <= '0;
            disp_q[1] <= '0;
            disp_q[2] <= '0;
        end else if (en && we && idx != 2'd3) begin
            disp_q[idx] <= wdata;
        end
    end

    // same latency as the memories.
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= (idx == 2'd3) ? 8'h00 : disp_q[idx];
        end
    end

    assign hex0 = seg7(disp_q[0][3:0]);
    assign hex1 = seg7(disp_q[0][7:4]);
    assign hex2 = seg7(disp_q[1][3:0]);
    assign hex3 = seg7(disp_q[1][7:4]);
    assign hex4 = seg7(disp_q[2][3:0]);
    assign hex5 = seg7(disp_q[2][7:4]);

endmodule

// File: src/main_ram.sv
`timescale 1ns/1ps

module main_ram #(
    parameter int RAM_AW = 14
) (
    input  logic              clk,
    input  logic              en,
    input  logic              we,
    input  logic [RAM_AW-1:0] addr,
    input  logic [7:0]        wdata,
    output logic [7:0]        rdata
);

    logic [7:0] mem [0:(2**RAM_AW)-1];

    // read-first, a write returns the old byte.
    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                mem[addr] <= wdata;
            end
            rdata <= mem[addr];
        end
    end

endmodule

// File: src/resp_stage.sv
`timescale 1ns/1ps

module resp_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cap_valid,
    input  logic                  is_write,
    input  fabric_pkg::target_e   sel,
    input  logic [7:0]            ram_rdata,
    input  logic [7:0]            rom_rdata,
    input  logic [7:0]            hex_rdata,
    output logic                  adv,
    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output fabric_pkg::host_rsp_t rsp
);

    import fabric_pkg::*;

    logic       s2_valid;
    logic       s2_write;
    target_e    s2_sel;
    logic [7:0] rd_mux;

    // move when the output slot is free or draining.
    assign adv = ~rsp_valid | rsp_ready;

    // ******************************
    // stage 2, beside the memory read
    // ******************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s2_valid <= 1'b0;
        end else if (adv) begin
            s2_valid <= cap_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (adv) begin
            s2_sel   <= sel;
            s2_write <= is_write;
        end
    end

    always_comb begin
        case (s2_sel)
            tgt_ram: rd_mux = ram_rdata;
            tgt_rom: rd_mux = rom_rdata;
            tgt_hex: rd_mux = hex_rdata;
            default: rd_mux = unmapped_data;
        endcase
    end

    // ******************************
    // response register
    // ******************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else if (adv) begin
            rsp_valid <= s2_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (adv) begin
            rsp.rdata  <= s2_write ? 8'h00 : rd_mux;
            rsp.wr_ack <= s2_write;
        end
    end

endmodule
